//--- Makefile
# Verilator build and run of the slot system testbench

TOP := tb_msx_slot

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)
	verilator --lint-only hdl/msx_pkg.sv hdl/slot_select_regs.sv hdl/sdram_map.sv \
		hdl/bus_sequencer.sv hdl/msx_slot_top.sv --top-module msx_slot_top

clean:
	rm -rf obj_dir sim.log

//--- files.f
hdl/msx_pkg.sv
hdl/slot_select_regs.sv
hdl/sdram_map.sv
hdl/bus_sequencer.sv
hdl/msx_slot_top.sv
sim/msx_slot_assertions.sv
sim/tb_msx_slot.sv

//--- hdl/bus_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer (
	input	wire							clk42m,
	input	wire							ff_reset_n,
	input	wire							cpu_req,
	input	msx_pkg::cpu_cmd_t				cpu_cmd,
	output	logic							cpu_ack,
	output	logic [7:0]						cpu_rdata,
	output	msx_pkg::cpu_cmd_t				cmd,
	input	msx_pkg::slot_route_t			route,
	input	wire [7:0]						reg_rdata,
	input	wire [msx_pkg::sdram_aw-1:0]	mem_addr,
	input	wire							mem_allowed,
	output	logic							reg_wr,
	output	logic							mem_req,
	output	msx_pkg::mem_cmd_t				mem_cmd,
	input	wire							mem_ack,
	input	wire [7:0]						mem_rdata
);
	import msx_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,		// Wait for cpu_req
		ST_DECODE,		// Command latched, route settles
		ST_MEM,			// SDRAM handshake open
		ST_DONE			// Ack high, wait for both req sides low
	} seq_state_t;

	seq_state_t	ff_state;
	cpu_cmd_t	ff_cmd;
	mem_cmd_t	ff_mem_cmd;
	logic [7:0]	ff_rdata;
	logic		ff_cpu_ack;
	logic		ff_mem_req;

	assign cmd			= ff_cmd;
	assign mem_cmd		= ff_mem_cmd;
	assign cpu_ack		= ff_cpu_ack;
	assign mem_req		= ff_mem_req;
	assign cpu_rdata	= ff_rdata;
	assign reg_wr		= (ff_state == ST_DECODE) && route.reg_hit;		// One cycle only

	// ------------------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_state	<= ST_IDLE;
			ff_cpu_ack	<= 1'b0;
			ff_mem_req	<= 1'b0;
		end
		else begin
			case (ff_state)
			ST_IDLE: begin
				if (cpu_req) begin
					ff_state <= ST_DECODE;
				end
			end
			ST_DECODE: begin
				if (!route.reg_hit && mem_allowed) begin
					ff_mem_req	<= 1'b1;
					ff_state	<= ST_MEM;
				end
				else begin
					ff_cpu_ack	<= 1'b1;		// Register or open bus
					ff_state	<= ST_DONE;
				end
			end
			ST_MEM: begin
				if (mem_ack) begin
					ff_mem_req	<= 1'b0;		// Drop req as ack goes up
					ff_cpu_ack	<= 1'b1;
					ff_state	<= ST_DONE;
				end
			end
			default: begin
				// SDRAM side must be quiet too before the next access
				if (!cpu_req && !mem_ack) begin
					ff_cpu_ack	<= 1'b0;
					ff_state	<= ST_IDLE;
				end
			end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Command latch and read data mux
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (ff_state == ST_IDLE && cpu_req) begin
			ff_cmd <= cpu_cmd;
		end
		if (ff_state == ST_DECODE) begin
			ff_mem_cmd <= '{write: ff_cmd.write, addr: mem_addr, wdata: ff_cmd.wdata};
			if (route.reg_hit) begin
				ff_rdata <= ff_cmd.write ? open_bus_data : reg_rdata;
			end
			else if (!mem_allowed) begin
				ff_rdata <= open_bus_data;		// Nothing answers
			end
		end
		if (ff_state == ST_MEM && mem_ack) begin
			ff_rdata <= ff_cmd.write ? open_bus_data : mem_rdata;
		end
	end

endmodule

`default_nettype wire

//--- hdl/msx_pkg.sv
`default_nettype none

package msx_pkg;

	// ------------------------------------------------------------------------
	// Bus decode constants
	// ------------------------------------------------------------------------
	localparam logic [7:0]	slot_port_addr	= 8'hA8;	// PPI port A, primary slot
	localparam logic [15:0]	sec_slot_addr	= 16'hFFFF;	// Expanded slot register
	localparam logic [7:0]	open_bus_data	= 8'hFF;	// Pulled-up data bus

	localparam int			sdram_aw		= 23;		// 8 MB of byte addresses

	// ------------------------------------------------------------------------
	// SDRAM region prefixes, upper address bits above the page offset
	// ------------------------------------------------------------------------
	localparam logic [6:0]	region_mapper_ram	= 7'b100_0000;		// + a[15:13]
	localparam logic [7:0]	region_rom_1m		= 8'b010_0000_0;	// + ~a14, a13
	localparam logic [9:0]	region_rom_512k		= 10'b000_0100_000;	// Fixed base
	localparam logic [7:0]	region_logo_rom		= 8'b000_0011_1;	// Logo, ExtBASIC
	localparam logic [8:0]	region_music_rom	= 9'b000_0011_01;
	localparam logic [8:0]	region_iot_basic	= 9'b000_0011_00;
	localparam logic [7:0]	region_sub_rom		= 8'b000_0010_1;
	localparam logic [7:0]	region_main_rom		= 8'b000_0010_0;
	localparam logic [6:0]	region_nextor		= 7'b000_0000;		// + a[15:13]

	// CPU side command, held stable for the whole access
	typedef struct packed {
		logic			is_io;		// I/O cycle, else memory
		logic			write;
		logic [15:0]	addr;
		logic [7:0]		wdata;
	} cpu_cmd_t;

	// Command to the SDRAM controller
	typedef struct packed {
		logic					write;
		logic [sdram_aw-1:0]	addr;
		logic [7:0]				wdata;
	} mem_cmd_t;

	typedef struct packed {
		logic [1:0]	primary;	// Slot of the current page
		logic [1:0]	secondary;	// Sub slot, 0 when not expanded
		logic		expanded;
		logic		reg_hit;	// Access lands on a slot register
	} slot_route_t;

endpackage

`default_nettype wire

//--- hdl/msx_slot_top.sv
`timescale 1ns/1ps
`default_nettype none

module msx_slot_top (
	input	wire							clk42m,
	input	wire							ff_reset_n,
	// CPU command port
	input	wire							cpu_req,
	input	msx_pkg::cpu_cmd_t				cpu_cmd,
	output	logic							cpu_ack,
	output	logic [7:0]						cpu_rdata,
	// SDRAM controller port
	output	logic							mem_req,
	output	msx_pkg::mem_cmd_t				mem_cmd,
	input	wire							mem_ack,
	input	wire [7:0]						mem_rdata
);
	import msx_pkg::*;

	cpu_cmd_t				w_cmd;			// Latched command
	slot_route_t			w_route;
	logic [7:0]				w_reg_rdata;
	logic					w_reg_wr;
	logic [sdram_aw-1:0]	w_mem_addr;
	logic					w_mem_allowed;

	// ------------------------------------------------------------------------
	// Slot registers, map, sequencer
	// ------------------------------------------------------------------------
	slot_select_regs u_regs (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.cmd			(w_cmd),
		.reg_wr			(w_reg_wr),
		.route			(w_route),
		.reg_rdata		(w_reg_rdata)
	);

	sdram_map u_map (
		.cmd			(w_cmd),
		.route			(w_route),
		.mem_addr		(w_mem_addr),
		.mem_allowed	(w_mem_allowed)
	);

	bus_sequencer u_seq (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.cpu_req		(cpu_req),
		.cpu_cmd		(cpu_cmd),
		.cpu_ack		(cpu_ack),
		.cpu_rdata		(cpu_rdata),
		.cmd			(w_cmd),
		.route			(w_route),
		.reg_rdata		(w_reg_rdata),
		.mem_addr		(w_mem_addr),
		.mem_allowed	(w_mem_allowed),
		.reg_wr			(w_reg_wr),
		.mem_req		(mem_req),
		.mem_cmd		(mem_cmd),
		.mem_ack		(mem_ack),
		.mem_rdata		(mem_rdata)
	);

endmodule

`default_nettype wire

//--- hdl/sdram_map.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_map (
	input	msx_pkg::cpu_cmd_t				cmd,
	input	msx_pkg::slot_route_t			route,
	output	logic [msx_pkg::sdram_aw-1:0]	mem_addr,
	output	logic							mem_allowed
);
	import msx_pkg::*;

	logic [9:0]	region_hi;		// SDRAM address bits 22:13
	logic		rd_ok;
	logic		wr_ok;
	logic [1:0]	page;
	logic		mid_pages;		// 4000h-BFFFh
	logic		low_pages;		// 0000h-7FFFh

	assign page			= cmd.addr[15:14];
	assign mid_pages	= (page == 2'd1) || (page == 2'd2);
	assign low_pages	= !cmd.addr[15];

	// ------------------------------------------------------------------------
	// Region select, priority order of the slot table
	// ------------------------------------------------------------------------
	always_comb begin
		region_hi	= 10'd0;		// 3-3 is empty
		rd_ok		= 1'b0;
		wr_ok		= 1'b0;
		if (route.primary == 2'd3 && route.secondary == 2'd0) begin
			region_hi	= {region_mapper_ram, cmd.addr[15:13]};		// Mapper RAM
			rd_ok		= 1'b1;
			wr_ok		= 1'b1;		// Only writable region
		end
		else if (route.primary == 2'd1) begin
			region_hi	= {region_rom_1m, ~cmd.addr[14], cmd.addr[13]};
			rd_ok		= mid_pages;
		end
		else if (route.primary == 2'd2) begin
			region_hi	= region_rom_512k;
			rd_ok		= mid_pages;
		end
		else if (route.primary == 2'd0 && route.secondary == 2'd3) begin
			region_hi	= {region_logo_rom, cmd.addr[14:13]};
			rd_ok		= mid_pages;
		end
		else if (route.primary == 2'd0 && route.secondary == 2'd2) begin
			region_hi	= {region_music_rom, cmd.addr[13]};		// 16 KB at 4000h
			rd_ok		= (page == 2'd1);
		end
		else if (route.primary == 2'd0 && route.secondary == 2'd1) begin
			region_hi	= {region_iot_basic, cmd.addr[13]};
			rd_ok		= (page == 2'd1);
		end
		else if (route.primary == 2'd3 && route.secondary == 2'd1) begin
			region_hi	= {region_sub_rom, cmd.addr[14:13]};
			rd_ok		= low_pages;
		end
		else if (route.primary == 2'd0 && route.secondary == 2'd0) begin
			region_hi	= {region_main_rom, cmd.addr[14:13]};		// BIOS + BASIC
			rd_ok		= low_pages;
		end
		else if (route.primary == 2'd3 && route.secondary == 2'd2) begin
			region_hi	= {region_nextor, cmd.addr[15:13]};
			rd_ok		= mid_pages;
		end
	end

	assign mem_addr		= {region_hi, cmd.addr[12:0]};		// 8 KB offset passes through

	// No SDRAM cycle for I/O or slot register hits
	assign mem_allowed	= !cmd.is_io && !route.reg_hit && (cmd.write ? wr_ok : rd_ok);

endmodule

`default_nettype wire

//--- hdl/slot_select_regs.sv
`timescale 1ns/1ps
`default_nettype none

module slot_select_regs (
	input	wire					clk42m,
	input	wire					ff_reset_n,
	input	msx_pkg::cpu_cmd_t		cmd,
	input	wire					reg_wr,
	output	msx_pkg::slot_route_t	route,
	output	logic [7:0]				reg_rdata
);
	import msx_pkg::*;

	logic [7:0]	ff_prim_slot;		// Two bits per page
	logic [7:0]	ff_sec_slot0;		// Slot 0 expansion register
	logic [7:0]	ff_sec_slot3;		// Slot 3 expansion register
	logic [1:0]	page;
	logic [1:0]	prim;
	logic		expanded;
	logic [7:0]	sec_reg;
	logic		io_hit;
	logic		mem_hit;

	// ------------------------------------------------------------------------
	// Route decode for the latched access
	// ------------------------------------------------------------------------
	assign page		= cmd.addr[15:14];
	assign prim		= ff_prim_slot[{page, 1'b0} +: 2];
	assign expanded	= (prim == 2'd0) || (prim == 2'd3);		// Only 0 and 3 expanded
	assign sec_reg	= (prim == 2'd0) ? ff_sec_slot0 : ff_sec_slot3;

	// Port A8h hit
	assign io_hit	= cmd.is_io && (cmd.addr[7:0] == slot_port_addr);
	// FFFFh is page 3, so prim is already the page-3 slot here
	assign mem_hit	= !cmd.is_io && (cmd.addr == sec_slot_addr) && expanded;

	assign route.primary	= prim;
	assign route.secondary	= expanded ? sec_reg[{page, 1'b0} +: 2] : 2'd0;
	assign route.expanded	= expanded;
	assign route.reg_hit	= io_hit || mem_hit;

	// Secondary reads back inverted, as on real hardware
	assign reg_rdata		= io_hit ? ff_prim_slot : ~sec_reg;

	// ------------------------------------------------------------------------
	// Register writes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_prim_slot <= 8'h00;		// Everything in slot 0-0 after reset
			ff_sec_slot0 <= 8'h00;
			ff_sec_slot3 <= 8'h00;
		end
		else if (reg_wr && cmd.write) begin
			if (io_hit) begin
				ff_prim_slot <= cmd.wdata;
			end
			else if (mem_hit) begin
				if (prim == 2'd0) begin
					ff_sec_slot0 <= cmd.wdata;
				end
				else begin
					ff_sec_slot3 <= cmd.wdata;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/msx_slot_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module msx_slot_assertions (
	input	wire				clk42m,
	input	wire				ff_reset_n,
	input	wire				cpu_req,
	input	wire				cpu_ack,
	input	wire				mem_req,
	input	wire				mem_ack,
	input	msx_pkg::mem_cmd_t	mem_cmd
);

	int fail_count = 0;		// Failed assertions so far

	// ------------------------------------------------------------------------
	// Four-phase handshake rules
	// ------------------------------------------------------------------------
	// CPU ack only answers a request
	cpu_ack_needs_req: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		$rose(cpu_ack) |-> $past(cpu_req))
	else begin
		fail_count++;
		$error("cpu_ack rose without cpu_req");
	end

	// SDRAM ack only answers a request
	mem_ack_needs_req: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		$rose(mem_ack) |-> mem_req)
	else begin
		fail_count++;
		$error("mem_ack rose without mem_req");
	end

	// Command frozen for the whole SDRAM cycle
	mem_cmd_stable: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		(mem_req && $past(mem_req)) |-> $stable(mem_cmd))
	else begin
		fail_count++;
		$error("mem_cmd changed while mem_req was high");
	end

	mem_idle_at_ack: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		cpu_ack |-> !mem_req)		// One access in flight
	else begin
		fail_count++;
		$error("mem_req high while cpu_ack was high");
	end

endmodule

`default_nettype wire

//--- sim/msx_slot_vectors.txt
# name is_io write addr wdata exp_rdata exp_sdram_addr, all numbers hex
# exp_sdram_addr "none" means the access must not reach the SDRAM
rst_main_rd      0 0 1234 00 26 021234
rst_slot_rd      1 0 00a8 00 00 none
io_unmapped      1 0 0099 00 ff none
main_p2_rd       0 0 8000 00 ff none
slot_p1_s1_wr    1 1 00a8 04 ff none
slot_p1_s1_rd    1 0 00a8 00 04 none
rom1m_lo_rd      0 0 4567 00 62 200567
rom1m_hi_rd      0 0 6abc 00 96 202abc
slot_p12_s1_wr   1 1 00a8 14 ff none
rom1m_p2_rd      0 0 9f00 00 5f 205f00
slot_p0_s1_wr    1 1 00a8 01 ff none
rom1m_p0_rd      0 0 0100 00 ff none
slot_p1_s2_wr    1 1 00a8 08 ff none
rom512k_rd       0 0 5432 00 26 041432
slot_p3_s3_wr    1 1 00a8 c0 ff none
sec3_wr          0 1 ffff 09 ff none
sec3_rd          0 0 ffff 00 f6 none
slot_p013_s3_wr  1 1 00a8 cf ff none
subrom_rd        0 0 0345 00 c6 028345
nextor_rd        0 0 7001 00 71 007001
ram_wr           0 1 c123 5a ff 40c123
ram_rd           0 0 c123 00 5a 40c123
ram_top_wr       0 1 fffe a5 ff 40fffe
ram_top_rd       0 0 fffe 00 a5 40fffe
main_p2_rd_s3    0 0 8888 00 ff none
rom_wr           0 1 0345 77 ff none
rom_rd_after_wr  0 0 0345 00 c6 028345
slot_all_s0_wr   1 1 00a8 00 ff none
sec0_wr_logo     0 1 ffff 3c ff none
sec0_rd          0 0 ffff 00 c3 none
logo_rd          0 0 4100 00 c1 03c100
sec0_wr_music    0 1 ffff 28 ff none
music_rd         0 0 5000 00 50 035000
music_p2_rd      0 0 8000 00 ff none
sec0_wr_iot      0 1 ffff 04 ff none
iot_rd           0 0 6e0f 00 21 032e0f
slot_final_rd    1 0 00a8 00 00 none

//--- sim/tb_msx_slot.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_slot;
	import msx_pkg::*;

	// One line of the vector file
	typedef struct packed {
		logic			is_io;
		logic			write;
		logic [15:0]	addr;
		logic [7:0]		wdata;
		logic [7:0]		exp_rdata;
		logic			exp_mem;		// SDRAM request expected
		logic [22:0]	exp_addr;
	} vector_t;

	logic				clk42m;
	logic				ff_reset_n;
	logic				cpu_req;
	cpu_cmd_t			cpu_cmd;
	logic				cpu_ack;
	logic [7:0]			cpu_rdata;
	logic				mem_req;
	mem_cmd_t			mem_cmd;
	logic				mem_ack;
	logic [7:0]			mem_rdata;

	vector_t			vectors[$];
	string				names[$];
	logic				load_done = 1'b0;
	int					error_count = 0;
	int					failed_tests = 0;
	int					assert_fails;
	bit					load_ok;

	// SDRAM model state
	logic [7:0]			sdram_bytes[int];		// Sparse, written bytes only
	logic [22:0]		last_mem_addr = '0;
	int					mem_req_count = 0;
	logic [15:0]		lfsr_state = 16'd55;

	msx_slot_top u_msx_slot_top (
		.clk42m		(clk42m),
		.ff_reset_n	(ff_reset_n),
		.cpu_req	(cpu_req),
		.cpu_cmd	(cpu_cmd),
		.cpu_ack	(cpu_ack),
		.cpu_rdata	(cpu_rdata),
		.mem_req	(mem_req),
		.mem_cmd	(mem_cmd),
		.mem_ack	(mem_ack),
		.mem_rdata	(mem_rdata)
	);

	bind msx_slot_top msx_slot_assertions u_handshake_checks (
		.clk42m		(clk42m),
		.ff_reset_n	(ff_reset_n),
		.cpu_req	(cpu_req),
		.cpu_ack	(cpu_ack),
		.mem_req	(mem_req),
		.mem_ack	(mem_ack),
		.mem_cmd	(mem_cmd)
	);

	initial begin
		clk42m = 1'b0;
		forever #2 clk42m = ~clk42m;		// 4 ns period
	end

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic check_equal(input string test_name, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s %s: expected %h, actual %h",
				test_name, field, expected, actual);
			error_count++;
		end
	endtask

	// ------------------------------------------------------------------------
	// SDRAM controller model
	// ------------------------------------------------------------------------
	task automatic serve_mem_request();
		mem_cmd_t	c;
		int			delay;
		logic		b0;
		logic		b1;
		c = mem_cmd;
		mem_req_count++;
		last_mem_addr = c.addr;
		lfsr_state = lfsr_next(lfsr_state);
		b0 = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
		b1 = lfsr_state[0];
		delay = 1 + int'({b1, b0});		// 1 to 4 cycles
		repeat (delay - 1) begin
			@(posedge clk42m);
			#1;
		end
		if (c.write) begin
			sdram_bytes[int'(c.addr)] = c.wdata;
		end
		else if (sdram_bytes.exists(int'(c.addr))) begin
			mem_rdata = sdram_bytes[int'(c.addr)];
		end
		else begin
			mem_rdata = c.addr[7:0] ^ c.addr[15:8];		// Unwritten byte pattern
		end
		mem_ack = 1'b1;
		do begin
			@(posedge clk42m);
			#1;
		end while (mem_req);
		mem_ack = 1'b0;
	endtask

	initial begin
		mem_ack = 1'b0;
		mem_rdata = 8'h00;
		forever begin
			@(posedge clk42m);
			#1;
			if (mem_req && !mem_ack) begin
				serve_mem_request();
			end
		end
	end

	// ------------------------------------------------------------------------
	// Vector file and CPU accesses
	// ------------------------------------------------------------------------
	task automatic load_vectors(output bit ok);
		int				fd;
		int				n;
		string			line;
		string			name;
		string			sdram_str;
		logic [31:0]	f_io;
		logic [31:0]	f_wr;
		logic [31:0]	f_addr;
		logic [31:0]	f_wdata;
		logic [31:0]	f_rdata;
		logic [31:0]	f_sdram;
		vector_t		v;
		ok = 1'b0;
		fd = $fopen("sim/msx_slot_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open vector file sim/msx_slot_vectors.txt");
		end
		else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) == 0) break;
				if (line.len() == 0 || line.getc(0) == "#") continue;		// Column notes
				n = $sscanf(line, "%s %h %h %h %h %h %s", name, f_io, f_wr,
					f_addr, f_wdata, f_rdata, sdram_str);
				if (n <= 0) continue;
				if (n != 7) begin
					$display("Malformed vector line: %s", line);
					error_count++;
					continue;
				end
				v.is_io = f_io[0];
				v.write = f_wr[0];
				v.addr = f_addr[15:0];
				v.wdata = f_wdata[7:0];
				v.exp_rdata = f_rdata[7:0];
				v.exp_mem = (sdram_str != "none");
				f_sdram = '0;
				if (v.exp_mem) begin
					n = $sscanf(sdram_str, "%h", f_sdram);
				end
				v.exp_addr = f_sdram[22:0];
				vectors.push_back(v);
				names.push_back(name);
			end
			$fclose(fd);
			ok = (vectors.size() > 0);
			if (!ok) $display("Vector file holds no vectors");
		end
	endtask

	// Full four-phase CPU access
	task automatic run_access(input vector_t v, output logic [7:0] rdata,
			output int reqs, output logic [22:0] addr);
		int start_reqs;
		@(posedge clk42m);
		#1;
		start_reqs = mem_req_count;
		cpu_cmd = '{is_io: v.is_io, write: v.write, addr: v.addr, wdata: v.wdata};
		cpu_req = 1'b1;
		do begin
			@(posedge clk42m);
			#1;
		end while (!cpu_ack);
		rdata = cpu_rdata;
		cpu_req = 1'b0;
		do begin
			@(posedge clk42m);
			#1;
		end while (cpu_ack);
		reqs = mem_req_count - start_reqs;
		addr = last_mem_addr;
	endtask

	task automatic run_test(input int idx);
		vector_t		v;
		logic [7:0]		rdata;
		int				reqs;
		logic [22:0]	addr;
		int				errors_before;
		v = vectors[idx];
		errors_before = error_count;
		run_access(v, rdata, reqs, addr);
		check_equal(names[idx], "rdata", 32'(v.exp_rdata), 32'(rdata));
		if (v.exp_mem) begin
			check_equal(names[idx], "sdram requests", 32'd1, 32'(reqs));
			check_equal(names[idx], "sdram addr", 32'(v.exp_addr), 32'(addr));
		end
		else begin
			check_equal(names[idx], "sdram requests", 32'd0, 32'(reqs));		// Must stay off
		end
		if (error_count == errors_before) begin
			$display("%s: ok", names[idx]);
		end
		else begin
			failed_tests++;
			$display("%s: FAILED", names[idx]);
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------------
	initial begin
		cpu_req = 1'b0;
		cpu_cmd = '0;
		ff_reset_n = 1'b0;
		load_vectors(load_ok);
		if (!load_ok) begin
			$display("Test failed");
			$finish;
		end
		else begin
			load_done = 1'b1;
			repeat (4) @(posedge clk42m);
			#1;
			ff_reset_n = 1'b1;
			foreach (vectors[i]) begin
				run_test(i);
			end
			assert_fails = u_msx_slot_top.u_handshake_checks.fail_count;
			$display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
				vectors.size(), failed_tests, error_count, assert_fails);
			if (error_count == 0 && assert_fails == 0) begin
				$display("Test completed successfully");
			end
			else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	initial begin
		wait (load_done);
		repeat (vectors.size() * 40) @(posedge clk42m);		// Far above worst access
		$display("Watchdog expired after %0d cycles, an access never completed",
			vectors.size() * 40);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
